//--- vlog.f
+incdir+include
source/keyscan_pkg.sv
source/scan_event_capture.sv
source/key_hold_tracker.sv
source/cursor_stepper.sv
source/keyboard_control_top.sv
test/key_event_driver.sv
test/tb_keyboard_control.sv

//--- run_sim.sh
#!/bin/sh
# build and run the keyboard control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
   --top-module tb_keyboard_control -f vlog.f \
   -Mdir obj_dir -o sim_keyboard_control

# the simulator exits nonzero on $fatal, so its output is judged instead
output=$(./obj_dir/sim_keyboard_control 2>&1) || true
echo "$output"

if echo "$output" | grep -qF 'All tests passed!'; then
   exit 0
else
   exit 1
fi

//--- test/tb_keyboard_control.sv
`default_nettype none
`include "keyscan_macros.svh"

module tb_keyboard_control;

   timeunit 1ns;
   timeprecision 100ps;

   import keyscan_pkg::*;

   localparam int KEYS = `KEY_COUNT;

   typedef struct packed
   {
      logic [7:0]  code;
      logic [15:0] idle;     // cycles after the handshake
      logic [31:0] keys;     // keyboard_keys two cycles after req
      logic        pos_chk;
      logic [31:0] pos;
   } stim_t;

   localparam int N_STIM = 20;
   localparam stim_t STIM [0:N_STIM-1] = '{
      '{8'h01, 16'd2,    32'h0001_0000, 1'b0, 32'h0},
      '{8'h7F, 16'd2,    32'h0001_0000, 1'b0, 32'h0},  // index 127 is ignored
      '{8'h00, 16'd2,    32'h0001_0000, 1'b0, 32'h0},  // stall code
      '{8'h81, 16'd2,    32'h0000_0000, 1'b0, 32'h0},
      '{8'h0F, 16'd40,   32'h0000_0004, 1'b0, 32'h0},  // right
      '{8'h11, 16'd40,   32'h0000_0005, 1'b0, 32'h0},  // right and down
      '{8'h0E, 16'd40,   32'h0000_000D, 1'b0, 32'h0},  // left cancels right
      '{8'h8E, 16'd0,    32'h0000_0005, 1'b0, 32'h0},
      '{8'h91, 16'd0,    32'h0000_0004, 1'b0, 32'h0},
      '{8'h0C, 16'd100,  32'h0000_0024, 1'b0, 32'h0},  // m held for slow steps
      '{8'h8F, 16'd0,    32'h0000_0020, 1'b0, 32'h0},
      '{8'h8C, 16'd0,    32'h0000_0000, 1'b0, 32'h0},
      '{8'h0E, 16'd0,    32'h0000_0008, 1'b0, 32'h0},
      '{8'h10, 16'd3000, 32'h0000_000A, 1'b1, 32'h0},  // top left corner
      '{8'h8E, 16'd0,    32'h0000_0002, 1'b0, 32'h0},
      '{8'h90, 16'd0,    32'h0000_0000, 1'b0, 32'h0},
      '{8'h0F, 16'd0,    32'h0000_0004, 1'b0, 32'h0},
      '{8'h11, 16'd5400, 32'h0000_0005, 1'b1, 32'h0009_FDDF},  // 639,479
      '{8'h8F, 16'd0,    32'h0000_0001, 1'b0, 32'h0},
      '{8'h91, 16'd0,    32'h0000_0000, 1'b0, 32'h0}
   };

   logic         CLK_25MHZ;
   logic         reset_from_key;
   logic         event_req;
   logic         event_ack;
   key_event_u   event_code;
   logic [31:0]  keyboard_keys;
   logic [31:0]  mouse_pos;
   logic         send;
   logic [7:0]   code;
   logic         done;
   logic         hung;
   integer       seed;
   int           cycle_cnt = 0;
   int           limit;
   logic [16:0]  m_hold;    // held-key model with digit_1 in bit 16
   logic [9:0]   m_x;
   logic [9:0]   m_y;
   int           m_cnt;
   logic         m_slow;
   logic         req_seen;
   logic         pend_valid;
   key_event_u   pend;

   keyboard_control_top dut (.*);
   key_event_driver drv (.*);

   task automatic stop_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp)
      else
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic report_problem(input string what);
      $display("ERROR: %s", what);
      stop_run();
   endtask

   function automatic logic [16:0] key_mask(input logic [6:0] idx);
      return 17'b1 << (KEYS - int'(idx));
   endfunction

   function automatic logic held(input logic [6:0] idx);
      return |(m_hold & key_mask(idx));
   endfunction

   function automatic logic [9:0] move_axis(input logic [9:0] p, input logic lo, input logic hi,
                                            input logic [9:0] top);
      return (lo && !hi && p != 10'd0) ? p - 10'd1
           : (hi && !lo && p != top) ? p + 10'd1 : p;
   endfunction

   // reset plus key sweep and table with room for handshakes and random gaps
   function automatic int run_length();
      int total;
      total = 16 + 2 * KEYS * 16 + N_STIM * 16 + 200;
      for (int i = 0; i < N_STIM; i++)
      begin
         total = total + int'(STIM[i].idle);
      end
      return total;
   endfunction

   task automatic apply_event(input logic [7:0] ev, input int idle, input logic [31:0] exp_keys);
      int gap;
      gap  = idle + ($random(seed) & 3);
      code = ev;
      send = 1'b1;
      @(posedge event_req);
      repeat (2) @(posedge CLK_25MHZ);
      #2;
      check_word("keyboard_keys", keyboard_keys, exp_keys);
      @(posedge CLK_25MHZ);
      while (!done && !hung)
      begin
         @(posedge CLK_25MHZ);
      end
      assert (!hung)
      else
      begin
         report_problem("event_ack did not follow event_req within 4 cycles");
      end
      #2;
      send = 1'b0;
      while (done)
      begin
         @(posedge CLK_25MHZ);
      end
      repeat (gap) @(posedge CLK_25MHZ);
      #2;
   endtask

   ////////////////////
   // reference model
   ////////////////////

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         m_hold     = '0;
         m_x        = 10'd320;
         m_y        = 10'd240;
         m_cnt      = 0;
         m_slow     = 1'b0;
         req_seen   = 1'b0;
         pend_valid = 1'b0;
      end
      else
      begin
         // a step sees the keys held before this edge
         if (m_cnt == (m_slow ? `STEP_SLOW_CYCLES : `STEP_FAST_CYCLES) - 1)
         begin
            m_x    = move_axis(m_x, held(`KEY_IDX_LEFT), held(`KEY_IDX_RIGHT),
                               10'(`SCREEN_X_MAX));
            m_y    = move_axis(m_y, held(`KEY_IDX_UP), held(`KEY_IDX_DOWN), 10'(`SCREEN_Y_MAX));
            m_cnt  = 0;
            m_slow = held(`KEY_IDX_M);
         end
         else
         begin
            m_cnt = m_cnt + 1;
         end
         if (pend_valid && pend.fields.key_index >= 7'd1 && pend.fields.key_index <= 7'(KEYS))
         begin
            m_hold = pend.fields.is_break ? m_hold & ~key_mask(pend.fields.key_index)
                                          : m_hold | key_mask(pend.fields.key_index);
         end
         pend_valid = event_req && !req_seen && (event_code.raw != `EVENT_NONE);
         pend       = event_code;
         req_seen   = event_req;
      end
   end

   always @(negedge CLK_25MHZ)
   begin
      if (!reset_from_key)
      begin
         check_word("mouse_pos", mouse_pos, {12'd0, m_x, m_y});
      end
   end

   always @(posedge CLK_25MHZ)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > limit)
      begin
         report_problem("timeout, the run did not finish in the expected number of cycles");
      end
   end

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever
      begin
         #20 CLK_25MHZ = ~CLK_25MHZ;
      end
   end

   initial
   begin
      seed           = 32'h87617090;
      reset_from_key = 1'b1;
      send           = 1'b0;
      code           = 8'h00;
      limit          = run_length();
      repeat (16) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;
      @(negedge CLK_25MHZ);
      check_word("keyboard_keys", keyboard_keys, 32'h0);
      check_word("event_ack", {31'd0, event_ack}, 32'h0);
      check_word("mouse_pos", mouse_pos, 32'h0005_00F0);  // 320,240
      @(posedge CLK_25MHZ);
      #2;
      // each key alone with its bit from the field order
      for (int k = 1; k <= KEYS; k++)
      begin
         apply_event({1'b0, 7'(k)}, 0, {15'd0, key_mask(7'(k))});
         apply_event({1'b1, 7'(k)}, 0, 32'h0);
      end
      for (int i = 0; i < N_STIM; i++)
      begin
         apply_event(STIM[i].code, int'(STIM[i].idle), STIM[i].keys);
         if (STIM[i].pos_chk)
         begin
            check_word("mouse_pos", mouse_pos, STIM[i].pos);
         end
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/key_event_driver.sv
`default_nettype none
`include "keyscan_macros.svh"

// runs one four-phase req/ack handshake each time send is seen high
module key_event_driver
(
   input  logic                    CLK_25MHZ,
   input  logic                    send,        // held high until done
   input  logic [7:0]              code,
   input  logic                    event_ack,
   output logic                    event_req,
   output keyscan_pkg::key_event_u event_code,
   output logic                    done,
   output logic                    hung         // ack missed its 4 cycle window
);

   timeunit 1ns;
   timeprecision 100ps;

   task automatic wait_ack(input logic level);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < 4)
      begin
         @(posedge CLK_25MHZ);
         #2;
         seen = (event_ack == level);
         n    = n + 1;
      end
      if (!seen)
      begin
         hung = 1'b1;
      end
   endtask

   initial
   begin
      event_req  = 1'b0;
      event_code = `EVENT_NONE;
      done       = 1'b0;
      hung       = 1'b0;
      forever
      begin
         @(posedge CLK_25MHZ);
         if (send && !done)
         begin
            #2;
            event_code = code;   // stable until ack rises
            event_req  = 1'b1;
            wait_ack(1'b1);
            event_req  = 1'b0;
            wait_ack(1'b0);
            done = 1'b1;
         end
         else if (!send && done)
         begin
            #2;
            done = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/keyboard_control_top.sv
`default_nettype none

// keyboard control path: capture, hold tracking, pointer stepping
module keyboard_control_top
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic                    event_req,
   input  keyscan_pkg::key_event_u event_code,
   output logic                    event_ack,
   output logic [31:0]             keyboard_keys,
   output logic [31:0]             mouse_pos
);

   import keyscan_pkg::*;

   logic         key_event_valid;  // stage 1 -> 2 strobe
   key_event_u   key_event;
   key_hold_t    key_hold;         // stage 2 -> 3, held continuously

   ////////////////////
   // stage 1
   ////////////////////

   scan_event_capture u_capture
   (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .event_req       (event_req),
      .event_code      (event_code),
      .event_ack       (event_ack),
      .key_event_valid (key_event_valid),
      .key_event       (key_event)
   );

   ////////////////////
   // stage 2
   ////////////////////

   key_hold_tracker u_tracker
   (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .key_hold        (key_hold),
      .keyboard_keys   (keyboard_keys)
   );

   ////////////////////
   // stage 3
   ////////////////////

   cursor_stepper u_stepper
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_hold       (key_hold),
      .pointer_pos    (),           // only the packed word leaves the top
      .mouse_pos      (mouse_pos)
   );

endmodule

`default_nettype wire

//--- source/cursor_stepper.sv
`default_nettype none
`include "keyscan_macros.svh"

// arrow keys move the pointer one pixel per step period
module cursor_stepper
(
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  keyscan_pkg::key_hold_t    key_hold,
   output keyscan_pkg::pointer_pos_t pointer_pos,
   output logic [31:0]               mouse_pos
);

   import keyscan_pkg::*;

   // wide enough for the slow period, which is the longer one
   localparam int CNT_W = $clog2(`STEP_SLOW_CYCLES);

   localparam logic [9:0] X_MAX  = 10'(`SCREEN_X_MAX);
   localparam logic [9:0] Y_MAX  = 10'(`SCREEN_Y_MAX);
   localparam logic [9:0] X_HOME = 10'((`SCREEN_X_MAX + 1) / 2);  // 320
   localparam logic [9:0] Y_HOME = 10'((`SCREEN_Y_MAX + 1) / 2);  // 240

   logic [CNT_W-1:0] step_cnt;
   logic [CNT_W-1:0] period_last;  // count value that fires a step
   logic             slow_sel;     // m was held when the period started
   logic             step;
   pointer_pos_t     pos_next;

   // one axis: move toward 0 or toward limit, opposite keys cancel
   function automatic logic [9:0] step_axis
   (
      input logic [9:0] pos,
      input logic       dec,
      input logic       inc,
      input logic [9:0] limit
   );
      logic [9:0] res;
      res = pos;
      if (dec && !inc && pos != 10'd0)
      begin
         res = pos - 10'd1;
      end
      else if (inc && !dec && pos != limit)
      begin
         res = pos + 10'd1;
      end
      return res;
   endfunction

   ////////////////////
   // step timer
   ////////////////////

   assign period_last = slow_sel ? CNT_W'(`STEP_SLOW_CYCLES - 1)
                                 : CNT_W'(`STEP_FAST_CYCLES - 1);
   assign step        = (step_cnt == period_last);

   // period for the next round is picked from m on the step cycle
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         step_cnt <= '0;
         slow_sel <= 1'b0;
      end
      else if (step)
      begin
         step_cnt <= '0;
         slow_sel <= key_hold.m;
      end
      else
      begin
         step_cnt <= step_cnt + 1'b1;
      end
   end

   ////////////////////
   // pointer position
   ////////////////////

   always_comb
   begin
      pos_next = pointer_pos;
      if (step)
      begin
         pos_next.x = step_axis(pointer_pos.x, key_hold.left, key_hold.right, X_MAX);
         pos_next.y = step_axis(pointer_pos.y, key_hold.up, key_hold.down, Y_MAX);
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         pointer_pos.x <= X_HOME;  // screen centre
         pointer_pos.y <= Y_HOME;
      end
      else
      begin
         pointer_pos <= pos_next;
      end
   end

   // processor port layout: 12 zero bits, x, y
   assign mouse_pos = {12'd0, pointer_pos.x, pointer_pos.y};

endmodule

`default_nettype wire

//--- source/key_hold_tracker.sv
`default_nettype none
`include "keyscan_macros.svh"

// make/break decoding into the held-key register
module key_hold_tracker
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic                    key_event_valid,
   input  keyscan_pkg::key_event_u key_event,
   output keyscan_pkg::key_hold_t  key_hold,
   output logic [31:0]             keyboard_keys
);

   import keyscan_pkg::*;

   key_hold_t hold_next;
   logic      make;  // 1 on press, 0 on release

   assign make = ~key_event.fields.is_break;

   ////////////////////
   // next held state
   ////////////////////

   always_comb
   begin
      hold_next = key_hold;
      if (key_event_valid)
      begin
         case (key_event.fields.key_index)
            `KEY_IDX_1:     hold_next.digit_1 = make;
            `KEY_IDX_2:     hold_next.digit_2 = make;
            `KEY_IDX_3:     hold_next.digit_3 = make;
            `KEY_IDX_4:     hold_next.digit_4 = make;
            `KEY_IDX_5:     hold_next.digit_5 = make;
            `KEY_IDX_6:     hold_next.digit_6 = make;
            `KEY_IDX_7:     hold_next.digit_7 = make;
            `KEY_IDX_8:     hold_next.digit_8 = make;
            `KEY_IDX_F1:    hold_next.f1      = make;
            `KEY_IDX_F2:    hold_next.f2      = make;
            `KEY_IDX_N:     hold_next.n       = make;
            `KEY_IDX_M:     hold_next.m       = make;
            `KEY_IDX_SPACE: hold_next.space   = make;
            `KEY_IDX_LEFT:  hold_next.left    = make;
            `KEY_IDX_RIGHT: hold_next.right   = make;
            `KEY_IDX_UP:    hold_next.up      = make;
            `KEY_IDX_DOWN:  hold_next.down    = make;
            default:
            begin
               // untracked key, nothing changes
            end
         endcase
      end
   end

   ////////////////////
   // registers
   ////////////////////

   // word for the processor port, upper bits always zero
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         key_hold      <= '0;
         keyboard_keys <= '0;
      end
      else
      begin
         key_hold      <= hold_next;
         keyboard_keys <= {{(32 - `KEY_COUNT){1'b0}}, hold_next};
      end
   end

endmodule

`default_nettype wire

//--- source/scan_event_capture.sv
`default_nettype none

// four-phase req/ack receiver for key events from the keyboard front end
module scan_event_capture
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic                    event_req,
   input  keyscan_pkg::key_event_u event_code,
   output logic                    event_ack,
   output logic                    key_event_valid,
   output keyscan_pkg::key_event_u key_event
);

   logic accept;     // new request while idle
   logic has_event;  // anything but the reserved zero byte

   assign accept    = event_req & ~event_ack;
   assign has_event = |event_code.raw;

   ////////////////////
   // handshake
   ////////////////////

   // event_ack doubles as the state bit: low = idle, high = waiting for req to drop
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         event_ack       <= 1'b0;
         key_event_valid <= 1'b0;
      end
      else
      begin
         key_event_valid <= 1'b0;  // single-cycle strobe
         if (accept)
         begin
            event_ack       <= 1'b1;
            key_event_valid <= has_event;  // stall codes are acked but dropped
         end
         else if (event_ack && !event_req)
         begin
            event_ack <= 1'b0;
         end
      end
   end

   ////////////////////
   // payload
   ////////////////////

   // code is stable while req is high and ack low
   always_ff @(posedge CLK_25MHZ)
   begin
      if (accept)
      begin
         key_event <= event_code;
      end
   end

endmodule

`default_nettype wire

//--- source/keyscan_pkg.sv
`default_nettype none

package keyscan_pkg;

   ////////////////////
   // key event byte
   ////////////////////

   typedef struct packed
   {
      logic       is_break;  // 1 = key released
      logic [6:0] key_index;
   } key_fields_t;

   // same byte read whole or split into flag and index
   typedef union packed
   {
      logic [7:0]  raw;
      key_fields_t fields;
   } key_event_u;

   ////////////////////
   // held keys
   ////////////////////

   // msb first, matches the low bits of the keyboard keys word
   typedef struct packed
   {
      logic digit_1;
      logic digit_2;
      logic digit_3;
      logic digit_4;
      logic digit_5;
      logic digit_6;
      logic digit_7;
      logic digit_8;
      logic f1;
      logic f2;
      logic n;
      logic m;      // slow pointer
      logic space;
      logic left;
      logic right;
      logic up;
      logic down;
   } key_hold_t;

   typedef struct packed
   {
      logic [9:0] x;
      logic [9:0] y;
   } pointer_pos_t;

endpackage

`default_nettype wire

//--- include/keyscan_macros.svh
`ifndef KEYSCAN_MACROS_SVH
`define KEYSCAN_MACROS_SVH

// keys watched by the design
`define KEY_COUNT 17

// event code key indices, 0 is never a key
`define KEY_IDX_1     7'd1
`define KEY_IDX_2     7'd2
`define KEY_IDX_3     7'd3
`define KEY_IDX_4     7'd4
`define KEY_IDX_5     7'd5
`define KEY_IDX_6     7'd6
`define KEY_IDX_7     7'd7
`define KEY_IDX_8     7'd8
`define KEY_IDX_F1    7'd9
`define KEY_IDX_F2    7'd10
`define KEY_IDX_N     7'd11
`define KEY_IDX_M     7'd12
`define KEY_IDX_SPACE 7'd13
`define KEY_IDX_LEFT  7'd14
`define KEY_IDX_RIGHT 7'd15
`define KEY_IDX_UP    7'd16
`define KEY_IDX_DOWN  7'd17

// 640x480 screen, inclusive limits
`define SCREEN_X_MAX 639
`define SCREEN_Y_MAX 479

// clocks between pointer steps, hardware would use far longer periods
`define STEP_FAST_CYCLES 8
`define STEP_SLOW_CYCLES 32

`define EVENT_NONE 8'h00 // reserved, no event

`endif
